// File: Bender.yml
package:
  name: div_unit

sources:
  - verilog/div_pkg.sv
  - verilog/div_req_if.sv
  - verilog/div_res_if.sv
  - verilog/div_operand_prep.sv
  - verilog/div_restoring_core.sv
  - verilog/div_result_fixup.sv
  - verilog/div_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/div_unit_tb.sv

// File: test/div_vectors.svh
/*
 * directed vectors for the divide unit
 * operation, dividend, divisor, expected result
 */

div_op_t     tab_op[$];
logic [63:0] tab_a[$];
logic [63:0] tab_b[$];
logic [63:0] tab_exp[$];

task automatic add_vec(input div_op_t op, input logic [63:0] a, b, exp);
  tab_op.push_back(op);
  tab_a.push_back(a);
  tab_b.push_back(b);
  tab_exp.push_back(exp);
endtask

task automatic fill_table();
  // signed for all four sign combinations
  add_vec(DIV, 64'd100, 64'd7, 64'd14);
  add_vec(DIV, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7, 64'hFFFF_FFFF_FFFF_FFF2);
  add_vec(DIV, 64'd100, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF2);
  add_vec(DIV, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 64'd14);
  add_vec(REM, 64'd100, 64'd7, 64'd2);
  add_vec(REM, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7, 64'hFFFF_FFFF_FFFF_FFFE);
  add_vec(REM, 64'd100, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2);
  add_vec(REM, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE);
  // unsigned full width
  add_vec(DIVU, 64'h8000_0000_0000_0000, 64'd3, 64'h2AAA_AAAA_AAAA_AAAA);
  add_vec(REMU, 64'h8000_0000_0000_0000, 64'd3, 64'd2);
  add_vec(DIVU, 64'h1234_5678_9ABC_DEF0, 64'h1_0000_0000, 64'h0000_0000_1234_5678);
  add_vec(REMU, 64'h1234_5678_9ABC_DEF0, 64'h1_0000_0000, 64'h0000_0000_9ABC_DEF0);
  // word forms with junk in the upper halves
  add_vec(DIVW, 64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, 64'hFFFF_FFFF_FFFF_FFF2);
  add_vec(REMW, 64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, 64'hFFFF_FFFF_FFFF_FFFE);
  add_vec(REMW, 64'hFFFF_FFFF_0000_0064, 64'h0000_0001_FFFF_FFF9, 64'd2);
  add_vec(DIVUW, 64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, 64'h0000_0000_2492_4916);
  add_vec(REMUW, 64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, 64'd2);
  add_vec(DIVUW, 64'h5555_0000_FFFF_FFF0, 64'hAAAA_0000_0000_0001, 64'h0000_0000_FFFF_FFF0);
  add_vec(REMUW, 64'h0123_4567_FFFF_FFFE, 64'h7654_3210_FFFF_FFFF, 64'h0000_0000_FFFF_FFFE);
  // divide by zero
  add_vec(DIV, 64'd5, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vec(DIVU, 64'h0123_4567_89AB_CDEF, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vec(DIVW, 64'h1234_5678_0000_0010, 64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vec(DIVUW, 64'd10, 64'h1_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vec(REM, 64'hFFFF_FFFF_FFFF_FF9C, 64'd0, 64'hFFFF_FFFF_FFFF_FF9C);
  add_vec(REMU, 64'hFEDC_BA98_7654_3210, 64'd0, 64'hFEDC_BA98_7654_3210);
  add_vec(REMW, 64'h1111_2222_8765_4321, 64'hABCD_0000_0000_0000, 64'hFFFF_FFFF_8765_4321);
  add_vec(REMUW, 64'h1111_2222_0000_0042, 64'd0, 64'h0000_0000_0000_0042);
  // most negative by minus one
  add_vec(DIV, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
  add_vec(REM, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0);
  add_vec(DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
  add_vec(REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'd0);
  add_vec(REMU, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
endtask

// File: test/div_unit_tb.sv
/*
 * testbench for the divide unit
 * directed table, random phase with a reference model,
 * stall and back-pressure checks
 */
`timescale 1ns/1ns

module div_unit_tb import div_pkg::*; ();

  localparam int          XLEN    = 64;
  localparam int          TIMEOUT = 200;
  localparam logic [63:0] MIN64   = 64'h8000_0000_0000_0000;
  localparam logic [31:0] MIN32   = 32'h8000_0000;

  logic        clk, rst_n;
  logic        div_valid, result_ready;
  div_op_t     div_type;
  logic [63:0] dividend, divisor, result;
  logic        div_stall, result_ok;
  logic [31:0] rng;

`include "div_vectors.svh"

  div_unit #(.XLEN(XLEN)) uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid),
    .div_type_i     (div_type),
    .dividend_i     (dividend),
    .divisor_i      (divisor),
    .result_ready_i (result_ready),
    .result_o       (result),
    .div_stall_o    (div_stall),
    .result_ok_o    (result_ok)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // random numbers and reference model
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    rng = xorshift32(rng);
    hi  = rng;
    rng = xorshift32(rng);
    return {hi, rng};
  endfunction

  function automatic logic is_word(div_op_t op);
    return (op == DIVW) || (op == DIVUW) || (op == REMW) || (op == REMUW);
  endfunction

  // zero divisor or signed overflow, no iteration expected
  function automatic logic expect_special(div_op_t op, logic [63:0] a, logic [63:0] b);
    logic sgn;
    sgn = (op == DIV) || (op == DIVW) || (op == REM) || (op == REMW);
    if (is_word(op)) begin
      return (b[31:0] == 0) || (sgn && a[31:0] == MIN32 && b[31:0] == '1);
    end
    return (b == 0) || (sgn && a == MIN64 && b == '1);
  endfunction

  function automatic logic [63:0] ref_result(div_op_t op, logic [63:0] a, logic [63:0] b);
    logic               ovf64, ovf32;
    logic signed [63:0] sd, sq, sr;
    logic signed [31:0] wd, wq, wr;
    logic [63:0]        ud, uq, ur, a_sx, r;
    logic [31:0]        uwd, uwq, uwr;
    ovf64 = (a == MIN64) && (b == '1);
    ovf32 = (a[31:0] == MIN32) && (b[31:0] == '1);
    // divisor forced to one where the result is fixed anyway
    sd   = (b == 0 || ovf64) ? 64'sd1 : $signed(b);
    ud   = (b == 0) ? 64'd1 : b;
    wd   = (b[31:0] == 0 || ovf32) ? 32'sd1 : $signed(b[31:0]);
    uwd  = (b[31:0] == 0) ? 32'd1 : b[31:0];
    sq   = $signed(a) / sd;
    sr   = $signed(a) % sd;
    uq   = a / ud;
    ur   = a % ud;
    wq   = $signed(a[31:0]) / wd;
    wr   = $signed(a[31:0]) % wd;
    uwq  = a[31:0] / uwd;
    uwr  = a[31:0] % uwd;
    a_sx = {{32{a[31]}}, a[31:0]};
    case (op)
      DIV:     r = (b == 0) ? '1 : (ovf64 ? MIN64 : sq);
      DIVU:    r = (b == 0) ? '1 : uq;
      REM:     r = (b == 0) ? a : (ovf64 ? 64'd0 : sr);
      REMU:    r = (b == 0) ? a : ur;
      DIVW:    r = (b[31:0] == 0) ? '1 : (ovf32 ? {32'hFFFF_FFFF, MIN32} : {{32{wq[31]}}, wq});
      DIVUW:   r = (b[31:0] == 0) ? '1 : {32'd0, uwq};
      REMW:    r = (b[31:0] == 0) ? a_sx : (ovf32 ? 64'd0 : {{32{wr[31]}}, wr});
      REMUW:   r = (b[31:0] == 0) ? a_sx : {32'd0, uwr};
      default: r = '0;
    endcase
    return r;
  endfunction

  // ----------------------------------------
  // checks and one operation
  // ----------------------------------------
  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic run_op(input div_op_t op, input logic [63:0] a, b, exp, input int hold,
                        input string what);
    int   waited;
    int   stall_cycles;
    int   exp_stall;
    logic special;
    logic stall_dropped;
    special   = expect_special(op, a, b);
    exp_stall = special ? 0 : (is_word(op) ? XLEN / 2 : XLEN);
    @(posedge clk);
    div_valid <= 1'b1;
    div_type  <= op;
    dividend  <= a;
    divisor   <= b;
    @(negedge clk);
    check_eq(div_stall, !special, {what, " stall on accept"});
    @(posedge clk);
    div_valid     <= 1'b0; // accepted on this edge
    waited        = 0;
    stall_cycles  = 0;
    stall_dropped = 1'b0;
    @(negedge clk);
    while (!result_ok) begin
      check_eq(result, '0, {what, " result while not ok"});
      if (div_stall) begin
        check_eq(stall_dropped, 1'b0, {what, " stall rose again"});
        stall_cycles++;
      end else begin
        stall_dropped = 1'b1;
      end
      waited++;
      if (waited >= TIMEOUT) begin
        $display("timeout, no result within %0d cycles for %s", TIMEOUT, what);
        $display("Checks failed");
        $fatal(1, "result never arrived");
      end
      @(negedge clk);
    end
    check_eq(stall_cycles, exp_stall, {what, " stall cycles"});
    check_eq(div_stall, 1'b0, {what, " stall with result ok"});
    check_eq(result, exp, what);
    repeat (hold) begin // back-pressure, result must hold
      @(negedge clk);
      check_eq(result_ok, 1'b1, {what, " ok dropped while held"});
      check_eq(result, exp, {what, " result changed while held"});
    end
    @(posedge clk);
    result_ready <= 1'b1;
    @(posedge clk);
    result_ready <= 1'b0;
    @(negedge clk);
    check_eq(result_ok, 1'b0, {what, " ok after release"});
    check_eq(result, '0, {what, " result after release"});
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    int          i;
    logic [63:0] r, a, b;
    div_op_t     op;
    rng          = 32'hb0d1_95a5;
    rst_n        = 1'b1; // reset asserted
    div_valid    = 1'b0;
    div_type     = '0;
    dividend     = '0;
    divisor      = '0;
    result_ready = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    check_eq(div_stall, 1'b0, "stall after reset");
    check_eq(result_ok, 1'b0, "result ok after reset");

    fill_table();
    for (i = 0; i < tab_op.size(); i++) begin
      r = rand64();
      run_op(tab_op[i], tab_a[i], tab_b[i], tab_exp[i], int'(r[2:0]), $sformatf("row %0d", i));
    end

    for (i = 0; i < 200; i++) begin
      r  = rand64();
      op = 8'd1 << r[2:0];
      a  = rand64();
      b  = rand64() >> r[8:3]; // spread of divisor sizes
      case (r[12:9])
        4'd0: b = r[13] ? 64'd0 : {b[63:32], 32'd0}; // zero divisor, full or low half
        4'd1: begin
          a = MIN64;
          b = '1;
        end
        4'd2: begin
          a[31:0] = MIN32;
          b[31:0] = '1;
        end
        4'd3: b = {60'd0, r[17:14]};
        default: ;
      endcase
      run_op(op, a, b, ref_result(op, a, b), int'(r[20:18]), $sformatf("random %0d", i));
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+test
verilog/div_pkg.sv
verilog/div_req_if.sv
verilog/div_res_if.sv
verilog/div_operand_prep.sv
verilog/div_restoring_core.sv
verilog/div_result_fixup.sv
verilog/div_unit.sv
test/div_unit_tb.sv

// File: verilog/div_operand_prep.sv
/*
 * input side of the divide unit
 * word sign extension, operand magnitudes,
 * divide-by-zero / overflow detection and acceptance control
 */
`timescale 1ns/1ns

module div_operand_prep import div_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            div_valid_i,
  input  div_op_t         div_type_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  output logic            div_stall_o,
  div_req_if.prep         req,
  div_res_if.prep         res
);

  localparam int HALF = XLEN / 2;
  localparam logic [XLEN-1:0] MIN_VAL  = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [HALF-1:0] HMIN_VAL = {1'b1, {(HALF-1){1'b0}}};

  logic            signed_op, word_op, rem_op;
  logic [XLEN-1:0] dvd_w, dvs_w;       // width-selected operands
  logic            neg_dvd, neg_dvs;
  logic [XLEN-1:0] dvd_mag, dvs_mag;
  logic            div_zero, div_of;
  logic            special_case;
  logic [XLEN-1:0] special_val;
  logic            accept;
  logic            special_q;

  assign signed_op = op_is_signed(div_type_i);
  assign word_op   = op_is_word(div_type_i);
  assign rem_op    = op_is_rem(div_type_i);

  // ----------------------------------------
  // width selection and magnitudes
  // ----------------------------------------
  assign dvd_w = word_op ? {{HALF{dividend_i[HALF-1]}}, dividend_i[HALF-1:0]} : dividend_i;
  assign dvs_w = word_op ? {{HALF{divisor_i[HALF-1]}}, divisor_i[HALF-1:0]} : divisor_i;

  assign neg_dvd = signed_op & dvd_w[XLEN-1];
  assign neg_dvs = signed_op & dvs_w[XLEN-1];

  assign dvd_mag = neg_dvd ? (~dvd_w + 1'b1) : dvd_w;
  assign dvs_mag = neg_dvs ? (~dvs_w + 1'b1) : dvs_w;

  // ----------------------------------------
  // special cases
  // ----------------------------------------
  always_comb begin
    if (word_op) begin
      div_zero = ~|divisor_i[HALF-1:0];
      div_of   = signed_op & (dividend_i[HALF-1:0] == HMIN_VAL) & (&divisor_i[HALF-1:0]);
    end else begin
      div_zero = ~|divisor_i;
      div_of   = signed_op & (dividend_i == MIN_VAL) & (&divisor_i);
    end

    special_val = '0; // remainder of an overflow
    if (div_zero) begin
      special_val = rem_op ? dvd_w : {XLEN{1'b1}};
    end else if (div_of && !rem_op) begin
      special_val = word_op ? {{HALF{1'b1}}, HMIN_VAL} : MIN_VAL;
    end
  end

  assign special_case = div_zero | div_of;

  // ----------------------------------------
  // acceptance and core request
  // ----------------------------------------
  // special_q keeps a second request out while the special result is in flight
  assign accept = div_valid_i & req.idle & ~res.busy_hold & ~special_q;

  assign req.start        = accept & ~special_case;
  assign req.word         = word_op;
  assign req.dividend_mag = word_op ? {dvd_mag[HALF-1:0], {HALF{1'b0}}} : dvd_mag;
  assign req.divisor_mag  = word_op ? {{HALF{1'b0}}, dvs_mag[HALF-1:0]} : dvs_mag;

  assign div_stall_o = req.start | ~req.idle; // accepting cycle plus iteration

  always_ff @(posedge clk) begin
    if (rst_n) begin
      special_q <= 1'b0;
    end else begin
      special_q <= accept & special_case; // one-cycle pulse
    end
  end

  // operation info for the output side
  always_ff @(posedge clk) begin
    if (accept) begin
      res.op          <= div_type_i;
      res.neg_q       <= neg_dvd ^ neg_dvs;
      res.neg_s       <= neg_dvd;
      res.special_val <= special_val;
    end
  end

  assign res.special = special_q;

endmodule

// File: verilog/div_pkg.sv
/*
 * shared definitions of the divide unit
 * one-hot operation codes and their width,
 * operation class helpers (signed / word / remainder)
 */
package div_pkg;

  localparam int OP_W = 8;

  typedef logic [OP_W-1:0] div_op_t; // one-hot, high to low as listed below

  // ----------------------------------------
  // operation codes
  // ----------------------------------------
  localparam div_op_t DIV   = 8'b1000_0000; // signed quotient, full width
  localparam div_op_t DIVU  = 8'b0100_0000; // unsigned quotient, full width
  localparam div_op_t DIVUW = 8'b0010_0000; // unsigned quotient, half width
  localparam div_op_t DIVW  = 8'b0001_0000; // signed quotient, half width
  localparam div_op_t REM   = 8'b0000_1000; // signed remainder, full width
  localparam div_op_t REMU  = 8'b0000_0100; // unsigned remainder, full width
  localparam div_op_t REMUW = 8'b0000_0010; // unsigned remainder, half width
  localparam div_op_t REMW  = 8'b0000_0001; // signed remainder, half width

  // ----------------------------------------
  // class helpers
  // ----------------------------------------

  // operands taken as two's complement
  function automatic logic op_is_signed(div_op_t op);
    return |(op & (DIV | DIVW | REM | REMW));
  endfunction

  // W form, low half of the operands only
  function automatic logic op_is_word(div_op_t op);
    return |(op & (DIVUW | DIVW | REMUW | REMW));
  endfunction

  // result is the remainder, not the quotient
  function automatic logic op_is_rem(div_op_t op);
    return |(op & (REM | REMU | REMUW | REMW));
  endfunction

endpackage

// File: verilog/div_req_if.sv
/*
 * request path from operand preparation to the divider core
 * start pulse, operand magnitudes, width flag, core idle level
 */
`timescale 1ns/1ns

interface div_req_if #(
  parameter int XLEN = 64
) ();

  logic            start;        // one cycle, load the core
  logic [XLEN-1:0] dividend_mag;  // word ops: magnitude sits in the upper half
  logic [XLEN-1:0] divisor_mag;
  logic            word;          // XLEN/2 iterations instead of XLEN
  logic            idle;          // core free to take a new operation

  modport prep (
    output start, dividend_mag, divisor_mag, word,
    input  idle
  );

  modport core (
    input  start, dividend_mag, divisor_mag, word,
    output idle
  );

endinterface

// File: verilog/div_res_if.sv
/*
 * result path into the output side
 * raw core result, captured operation info, special-case value, hold flag
 */
`timescale 1ns/1ns

interface div_res_if import div_pkg::*; #(
  parameter int XLEN = 64
) ();

  logic            done;         // core finished, quo/rem valid this cycle
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  div_op_t         op;            // captured at acceptance
  logic            neg_q;         // quotient needs negation
  logic            neg_s;         // remainder needs negation
  logic            special;       // divide by zero or overflow, use special_val
  logic [XLEN-1:0] special_val;
  logic            busy_hold;     // output side still holds a result

  modport core (output done, quo, rem);

  modport prep (
    output op, neg_q, neg_s, special, special_val,
    input  busy_hold
  );

  modport fixup (
    input  done, quo, rem, op, neg_q, neg_s, special, special_val,
    output busy_hold
  );

endinterface

// File: verilog/div_restoring_core.sv
/*
 * iterative restoring divider core
 * one quotient bit per clock on unsigned magnitudes,
 * XLEN or XLEN/2 iterations depending on the word flag
 */
`timescale 1ns/1ns

module div_restoring_core #(
  parameter int XLEN = 64
) (
  input  logic    clk,
  input  logic    rst_n,
  div_req_if.core req,
  div_res_if.core res
);

  localparam int CNT_W = $clog2(XLEN) + 1;

  logic [2*XLEN-1:0] rq;          // {remainder, quotient}
  logic [2*XLEN-1:0] rq_next;
  logic [XLEN-1:0]   dvsr;
  logic [CNT_W-1:0]  cnt;         // iterations left
  logic              busy;
  logic              done_q;

  logic [XLEN:0]     rem_sh;      // shifted remainder incl. the bit shifted out
  logic [XLEN+1:0]   diff;        // trial subtraction, msb is the borrow

  // ----------------------------------------
  // one iteration
  // ----------------------------------------
  assign rem_sh = rq[2*XLEN-1:XLEN-1];
  assign diff   = {1'b0, rem_sh} - {2'b0, dvsr};

  always_comb begin
    if (diff[XLEN+1]) begin
      // borrow, restore
      rq_next = {rem_sh[XLEN-1:0], rq[XLEN-2:0], 1'b0};
    end else begin
      rq_next = {diff[XLEN-1:0], rq[XLEN-2:0], 1'b1};
    end
  end

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst_n) begin
      busy   <= 1'b0;
      cnt    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (req.start) begin
        busy <= 1'b1;
        cnt  <= req.word ? CNT_W'(XLEN / 2) : CNT_W'(XLEN);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin // last quotient bit
          busy   <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (req.start) begin
      rq   <= {{XLEN{1'b0}}, req.dividend_mag};
      dvsr <= req.divisor_mag;
    end else if (busy) begin
      rq <= rq_next;
    end
  end

  assign req.idle = ~busy;
  assign res.done = done_q;
  assign res.quo  = rq[XLEN-1:0];
  assign res.rem  = rq[2*XLEN-1:XLEN];

endmodule

// File: verilog/div_result_fixup.sv
/*
 * output side of the divide unit
 * sign correction, quotient / remainder select, word extension,
 * result register held until the consumer is ready
 */
`timescale 1ns/1ns

module div_result_fixup import div_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            result_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            result_ok_o,
  div_res_if.fixup        res
);

  localparam int HALF = XLEN / 2;

  logic [XLEN-1:0] q_fix, r_fix;   // signs restored
  logic [XLEN-1:0] sel;
  logic [XLEN-1:0] fixed;
  logic [XLEN-1:0] result_q;
  logic            ok_q;
  logic            load;

  // ----------------------------------------
  // sign correction and selection
  // ----------------------------------------
  assign q_fix = res.neg_q ? (~res.quo + 1'b1) : res.quo;
  assign r_fix = res.neg_s ? (~res.rem + 1'b1) : res.rem;

  assign sel = op_is_rem(res.op) ? r_fix : q_fix;

  always_comb begin
    if (!op_is_word(res.op)) begin
      fixed = sel;
    end else if (op_is_signed(res.op)) begin
      fixed = {{HALF{sel[HALF-1]}}, sel[HALF-1:0]}; // divw / remw
    end else begin
      fixed = {{HALF{1'b0}}, sel[HALF-1:0]};        // divuw / remuw
    end
  end

  // ----------------------------------------
  // result hold
  // ----------------------------------------
  assign load = ~ok_q & (res.done | res.special);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ok_q <= 1'b0;
    end else if (ok_q) begin
      if (result_ready_i) begin
        ok_q <= 1'b0; // consumer took it
      end
    end else if (load) begin
      ok_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result_q <= res.special ? res.special_val : fixed;
    end
  end

  assign result_ok_o   = ok_q;
  assign result_o      = ok_q ? result_q : '0;
  assign res.busy_hold = ok_q; // blocks new requests in the prep

endmodule

// File: verilog/div_unit.sv
/*
 * divide unit top level
 * operand prep, restoring core and result fixup joined by two interfaces
 */
`timescale 1ns/1ns

module div_unit import div_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            div_valid_i,
  input  div_op_t         div_type_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  input  logic            result_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            div_stall_o,
  output logic            result_ok_o
);

  div_req_if #(.XLEN(XLEN)) req_if ();
  div_res_if #(.XLEN(XLEN)) res_if ();

  // input side
  div_operand_prep #(.XLEN(XLEN)) u_prep (
    .clk         (clk),
    .rst_n       (rst_n),
    .div_valid_i (div_valid_i),
    .div_type_i  (div_type_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .div_stall_o (div_stall_o),
    .req         (req_if.prep),
    .res         (res_if.prep)
  );

  div_restoring_core #(.XLEN(XLEN)) u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_if.core),
    .res   (res_if.core)
  );

  // output side
  div_result_fixup #(.XLEN(XLEN)) u_fixup (
    .clk            (clk),
    .rst_n          (rst_n),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .res            (res_if.fixup)
  );

endmodule
